/* cpu_pkg.sv */
package cpu_pkg;

  // sizes fixed by the instruction format
  localparam int data_w     = 16;
  localparam int num_regs   = 32;
  localparam int reg_idx_w  = 5;
  localparam int prog_words = 64;
  localparam int pc_w       = 6;
  localparam int pc_last    = 62;  // last word where an instruction may start

  localparam int paddr_w = 10;
  localparam int pdata_w = 32;

  // apb address map, byte addresses
  localparam logic [paddr_w-1:0] addr_ctrl      = 10'h000;  // bit 0 starts the machine
  localparam logic [paddr_w-1:0] addr_status    = 10'h004;  // busy, halted, error code
  localparam logic [paddr_w-1:0] addr_reg_base  = 10'h080;  // 32 registers, one per word
  localparam logic [paddr_w-1:0] addr_prog_base = 10'h100;  // 64 program words

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_num2reg   = 8'd18,
    op_reg_plus  = 8'd19,
    op_reg_minus = 8'd20,
    op_reg_mul   = 8'd21,
    op_reg_div   = 8'd22,
    op_exit      = 8'd27
  } opcode_e;

  typedef enum logic [2:0] {
    alu_set,
    alu_add,
    alu_sub,
    alu_mul,
    alu_div
  } alu_op_e;

  typedef enum logic [2:0] {
    err_none           = 3'd0,
    err_wrong_address  = 3'd1,
    err_divide_by_zero = 3'd2,
    err_wrong_reg_num  = 3'd3,
    err_wrong_opcode   = 3'd4
  } error_e;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch1,
    st_fetch2,
    st_issue,
    st_halt
  } decode_state_e;

endpackage

/* core_ifs.sv */
// one arithmetic op from decode to execute
interface exec_if import cpu_pkg::*; ();
  logic                 valid;
  logic                 ready;  // low while a range is being walked
  alu_op_e              op;
  logic [reg_idx_w-1:0] first;
  logic [reg_idx_w-1:0] last;
  logic [data_w-1:0]    value;

  modport source (output valid, op, first, last, value, input ready);
  modport sink (input valid, op, first, last, value, output ready);
endinterface

// register file access from execute, run status from decode
interface wb_if import cpu_pkg::*; ();
  logic [reg_idx_w-1:0] rd_idx;
  logic [data_w-1:0]    rd_data;
  logic                 wr_en;
  logic [reg_idx_w-1:0] wr_idx;
  logic [data_w-1:0]    wr_data;
  logic                 busy;
  logic                 halt_req;  // one cycle, error is valid with it
  error_e               error;

  modport execute (output rd_idx, wr_en, wr_idx, wr_data, input rd_data);
  modport status (output busy, halt_req, error);
  modport result (
    input  rd_idx, wr_en, wr_idx, wr_data, busy, halt_req, error,
    output rd_data
  );
endinterface

/* prog_mem.sv */
module prog_mem import cpu_pkg::*; (
  input  logic              clk,
  input  logic              wr_en,
  input  logic [pc_w-1:0]   wr_addr,
  input  logic [data_w-1:0] wr_data,
  input  logic [pc_w-1:0]   rd_addr,
  output logic [data_w-1:0] rd_data
);

  logic [data_w-1:0] mem [prog_words];  // loaded by the host before start

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // fetch data shows up one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* apb_host.sv */
module apb_host import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [paddr_w-1:0]   paddr,
  input  logic [pdata_w-1:0]   pwdata,
  output logic [pdata_w-1:0]   prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic                 busy,
  input  logic                 halted,
  input  error_e               error,
  output logic                 prog_wr_en,
  output logic [pc_w-1:0]      prog_wr_addr,
  output logic [data_w-1:0]    prog_wr_data,
  output logic                 start,
  output logic [reg_idx_w-1:0] reg_rd_idx,
  input  logic [data_w-1:0]    reg_rd_data
);

  logic               first_access;  // wait state cycle, the transfer acts here
  logic               hit_ctrl;
  logic               hit_status;
  logic               hit_reg;
  logic               hit_prog;
  logic [pdata_w-1:0] rd_word;

  assign first_access = psel && penable && !pready;

  assign hit_ctrl   = paddr == addr_ctrl;
  assign hit_status = paddr == addr_status;
  assign hit_reg    = paddr[1:0] == 2'b00 && paddr[paddr_w-1:7] == addr_reg_base[paddr_w-1:7];
  assign hit_prog   = paddr[1:0] == 2'b00 && paddr[paddr_w-1:8] == addr_prog_base[paddr_w-1:8];

  assign start        = first_access && pwrite && hit_ctrl && pwdata[0] && !busy;
  assign prog_wr_en   = first_access && pwrite && hit_prog && !busy;  // program frozen during a run
  assign prog_wr_addr = paddr[pc_w+1:2];
  assign prog_wr_data = pwdata[data_w-1:0];
  assign reg_rd_idx   = paddr[reg_idx_w+1:2];

  always_comb begin
    rd_word = '0;  // unmapped and write-only space reads as zero
    if (hit_status) begin
      rd_word[0]    = busy;
      rd_word[1]    = halted;
      rd_word[10:8] = error;
    end else if (hit_reg) begin
      rd_word[data_w-1:0] = reg_rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= first_access;
      pslverr <= first_access && pwrite && hit_prog && busy;
    end
  end

  always_ff @(posedge clk) begin
    if (first_access) begin
      prdata <= pwrite ? '0 : rd_word;
    end
  end

  a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pready |-> psel && penable);

endmodule

/* instr_decode.sv */
module instr_decode import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  output logic [pc_w-1:0]   fetch_addr,
  input  logic [data_w-1:0] fetch_data,
  exec_if.source            exec,
  wb_if.status              wb
);

  decode_state_e      state;
  logic [pc_w:0]      pc;         // extra bit lets the pc run past the last word
  logic [data_w-1:0]  instr1;     // first word, fetch_data holds the second in st_issue
  opcode_e            opcode;
  logic [reg_idx_w:0] range_end;  // first + count, may overflow the register file
  logic               is_arith;
  logic               halt_now;
  error_e             err;

  assign opcode    = opcode_e'(instr1[15:8]);
  assign range_end = {1'b0, instr1[4:0]} + {3'b000, instr1[7:5]};
  assign is_arith  = opcode inside {op_num2reg, op_reg_plus, op_reg_minus, op_reg_mul, op_reg_div};

  always_comb begin
    err = err_none;
    case (opcode)
      op_jmp: begin
        if (fetch_data[0]) err = err_wrong_address;  // targets must be even
      end
      op_num2reg, op_reg_plus, op_reg_minus, op_reg_mul: begin
        if (range_end >= num_regs) err = err_wrong_reg_num;
      end
      op_reg_div: begin
        if (fetch_data == '0) err = err_divide_by_zero;
        else if (range_end >= num_regs) err = err_wrong_reg_num;
      end
      op_exit: err = err_none;
      default: err = err_wrong_opcode;
    endcase
  end

  // stop requests wait for execute to drain so earlier ops land first
  assign halt_now = (state == st_issue && (err != err_none || opcode == op_exit)) ||
                    (state == st_fetch1 && pc > pc_last);
  assign wb.halt_req = halt_now && exec.ready;
  assign wb.error    = (state == st_issue) ? err : err_none;
  assign wb.busy     = state != st_idle && state != st_halt;

  assign fetch_addr = (state == st_fetch1) ? pc[pc_w-1:0] : pc[pc_w-1:0] + 1'b1;

  always_comb begin
    case (opcode)
      op_reg_plus:  exec.op = alu_add;
      op_reg_minus: exec.op = alu_sub;
      op_reg_mul:   exec.op = alu_mul;
      op_reg_div:   exec.op = alu_div;
      default:      exec.op = alu_set;
    endcase
  end

  assign exec.valid = state == st_issue && is_arith && err == err_none;
  assign exec.first = instr1[4:0];
  assign exec.last  = range_end[reg_idx_w-1:0];
  assign exec.value = fetch_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      pc    <= '0;
    end else begin
      case (state)
        st_idle, st_halt: begin
          if (start) begin
            pc    <= '0;
            state <= st_fetch1;
          end
        end
        st_fetch1: begin
          if (wb.halt_req) state <= st_halt;
          else if (pc <= pc_last) state <= st_fetch2;
        end
        st_fetch2: state <= st_issue;
        st_issue: begin
          if (wb.halt_req) begin
            state <= st_halt;
          end else if (!halt_now && opcode == op_jmp) begin
            // a target past the last word halts on the next fetch
            pc    <= (fetch_data > pc_last) ? (pc_w + 1)'(prog_words) : fetch_data[pc_w:0];
            state <= st_fetch1;
          end else if (exec.valid && exec.ready) begin
            pc    <= pc + 2'd2;
            state <= st_fetch1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch2) instr1 <= fetch_data;
  end

  a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    exec.valid && !exec.ready |=> exec.valid && $stable(exec.value));

endmodule

/* alu_execute.sv */
module alu_execute import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  exec_if.sink  exec,
  wb_if.execute wb
);

  logic                 walking;  // one register per cycle while high
  alu_op_e              op_q;
  logic [reg_idx_w-1:0] idx;
  logic [reg_idx_w-1:0] last_q;
  logic [data_w-1:0]    value_q;

  assign exec.ready = !walking;

  assign wb.rd_idx = idx;
  assign wb.wr_idx = idx;
  assign wb.wr_en  = walking;

  // results keep the low 16 bits
  always_comb begin
    case (op_q)
      alu_add: wb.wr_data = wb.rd_data + value_q;
      alu_sub: wb.wr_data = wb.rd_data - value_q;
      alu_mul: wb.wr_data = wb.rd_data * value_q;
      alu_div: wb.wr_data = (value_q == '0) ? '0 : wb.rd_data / value_q;
      default: wb.wr_data = value_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      walking <= 1'b0;
    end else if (exec.valid && exec.ready) begin
      walking <= 1'b1;
    end else if (walking && idx == last_q) begin
      walking <= 1'b0;  // ready comes back once the last write is in
    end
  end

  always_ff @(posedge clk) begin
    if (exec.valid && exec.ready) begin
      op_q    <= exec.op;
      idx     <= exec.first;
      last_q  <= exec.last;
      value_q <= exec.value;
    end else if (walking) begin
      idx <= idx + 1'b1;
    end
  end

  // decode must have filtered zero divisors
  a_no_div_zero: assert property (@(posedge clk) disable iff (!rst_n)
    wb.wr_en && op_q == alu_div |-> value_q != '0);

endmodule

/* reg_result.sv */
module reg_result import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  wb_if.result                 wb,
  input  logic [reg_idx_w-1:0] host_idx,
  output logic [data_w-1:0]    host_data,
  output logic                 busy,
  output logic                 halted,
  output error_e               error
);

  logic [data_w-1:0] regs [num_regs];

  assign wb.rd_data = regs[wb.rd_idx];  // execute side
  assign host_data  = regs[host_idx];   // apb side
  assign busy       = wb.busy;          // falls on the same edge halted rises

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wr_en) begin
      regs[wb.wr_idx] <= wb.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
      error  <= err_none;
    end else if (start) begin
      halted <= 1'b0;
      error  <= err_none;
    end else if (wb.halt_req) begin
      halted <= 1'b1;
      error  <= wb.error;
    end
  end

  // halt waits for execute to drain, so nothing may follow it
  a_no_write_halted: assert property (@(posedge clk) disable iff (!rst_n)
    wb.wr_en |-> !halted);

endmodule

/* cpu_top.sv */
module cpu_top import cpu_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [paddr_w-1:0] paddr,
  input  logic [pdata_w-1:0] pwdata,
  output logic [pdata_w-1:0] prdata,
  output logic               pready,
  output logic               pslverr
);

  logic                 prog_wr_en;
  logic [pc_w-1:0]      prog_wr_addr;
  logic [data_w-1:0]    prog_wr_data;
  logic [pc_w-1:0]      fetch_addr;
  logic [data_w-1:0]    fetch_data;
  logic                 start;
  logic [reg_idx_w-1:0] reg_rd_idx;
  logic [data_w-1:0]    reg_rd_data;
  logic                 busy;
  logic                 halted;
  error_e               error;

  exec_if exec_bus ();
  wb_if   wb_bus ();

  prog_mem prog_mem_i (
    .clk     (clk),
    .wr_en   (prog_wr_en),
    .wr_addr (prog_wr_addr),
    .wr_data (prog_wr_data),
    .rd_addr (fetch_addr),
    .rd_data (fetch_data)
  );

  apb_host apb_host_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .busy         (busy),
    .halted       (halted),
    .error        (error),
    .prog_wr_en   (prog_wr_en),
    .prog_wr_addr (prog_wr_addr),
    .prog_wr_data (prog_wr_data),
    .start        (start),
    .reg_rd_idx   (reg_rd_idx),
    .reg_rd_data  (reg_rd_data)
  );

  instr_decode instr_decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .exec       (exec_bus.source),
    .wb         (wb_bus.status)
  );

  alu_execute alu_execute_i (
    .clk   (clk),
    .rst_n (rst_n),
    .exec  (exec_bus.sink),
    .wb    (wb_bus.execute)
  );

  reg_result reg_result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .wb        (wb_bus.result),
    .host_idx  (reg_rd_idx),
    .host_data (reg_rd_data),
    .busy      (busy),
    .halted    (halted),
    .error     (error)
  );

endmodule

/* tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic               clk;
  logic               rst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [paddr_w-1:0] paddr;
  logic [pdata_w-1:0] pwdata;
  logic [pdata_w-1:0] prdata;
  logic               pready;
  logic               pslverr;

  logic [15:0] prog [64];      // program image that is loaded over apb and read by ref_run
  logic [15:0] exp_regs [32];  // registers persist across runs until a reset
  logic        exp_halted;
  int          errors;
  int          checks;
  int          timeouts;
  int          seed;

  cpu_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // expected machine that walks the program image and updates exp_regs
  function automatic int ref_run();
    int          pc;
    int          step;
    int          op;
    int          first;
    int          last;
    int          r;
    logic [15:0] val;
    exp_halted = 1'b1;
    pc = 0;
    for (step = 0; step < 1000; step++) begin
      if (pc > pc_last) return err_none;  // ran off the end
      op    = prog[pc][15:8];
      first = prog[pc][4:0];
      last  = first + prog[pc][7:5];
      val   = prog[pc+1];
      if (op == op_exit) return err_none;
      if (op == op_jmp) begin
        if (val[0]) return err_wrong_address;
        pc = val;
      end else if (op >= op_num2reg && op <= op_reg_div) begin
        if (op == op_reg_div && val == 0) return err_divide_by_zero;
        if (last >= num_regs) return err_wrong_reg_num;
        for (r = first; r <= last; r++) begin
          case (op)
            op_num2reg:   exp_regs[r] = val;
            op_reg_plus:  exp_regs[r] = exp_regs[r] + val;
            op_reg_minus: exp_regs[r] = exp_regs[r] - val;
            op_reg_mul:   exp_regs[r] = exp_regs[r] * val;
            default:      exp_regs[r] = exp_regs[r] / val;
          endcase
        end
        pc += 2;
      end else begin
        return err_wrong_opcode;
      end
    end
    exp_halted = 1'b0;  // endless jump loop
    return err_none;
  endfunction

  function automatic void fill_prog();
    int a;
    for (a = 0; a < prog_words; a++) begin
      prog[a] = 16'(a * 16'h0407) ^ 16'h5a3c;
    end
  endfunction

  function automatic void put_instr(int slot, logic [7:0] op, int first, int cnt,
                                    logic [15:0] value);
    prog[2*slot]     = {op, 3'(cnt), 5'(first)};
    prog[2*slot + 1] = value;
  endfunction

  function automatic void random_program();
    int          n;
    int          s;
    int          op;
    int          first;
    int          cnt;
    logic [15:0] value;
    fill_prog();
    n = 1 + $unsigned($random(seed)) % 20;
    for (s = 0; s < n; s++) begin
      op    = op_num2reg + $unsigned($random(seed)) % 5;
      first = $unsigned($random(seed)) % num_regs;
      cnt   = $unsigned($random(seed)) % 8;
      if (first + cnt >= num_regs) cnt = num_regs - 1 - first;  // keep the range legal
      value = $random(seed);
      if (op == op_reg_div) value = 16'(1 + $unsigned($random(seed)) % 7);
      put_instr(s, op, first, cnt, value);
    end
    put_instr(n, op_exit, 0, 0, 16'h0);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic apb_transfer(input logic write, input logic [paddr_w-1:0] addr,
                              input logic [pdata_w-1:0] wdata,
                              output logic [pdata_w-1:0] rdata, output logic err);
    int wait_cycles;
    rdata = '0;
    err   = 1'b0;
    if (timeouts != 0) return;
    @(negedge clk);
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    wait_cycles = 0;
    while (!pready && wait_cycles < 16) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!pready) begin
      timeouts++;
      $display("timeout: no pready for the access to address %h", addr);
    end else begin
      rdata = prdata;
      err   = pslverr;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [paddr_w-1:0] addr, input logic [pdata_w-1:0] data,
                           output logic err);
    logic [pdata_w-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [paddr_w-1:0] addr, output logic [pdata_w-1:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic check_read_zero(input logic [paddr_w-1:0] addr);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    if (timeouts == 0) check_eq($sformatf("read of %h", addr), data, 32'h0);
  endtask

  task automatic load_program();
    int   a;
    logic err;
    for (a = 0; a < prog_words; a++) begin
      apb_write(addr_prog_base + 10'(4*a), {16'h0, prog[a]}, err);
      if (timeouts == 0) check_eq("pslverr on program load", err, 1'b0);
    end
  endtask

  task automatic wait_halted(output logic [31:0] status);
    int   polls;
    logic err;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < 400 && timeouts == 0) begin
      apb_read(addr_status, status, err);
      polls++;
    end
    if (!status[1] && timeouts == 0) begin
      timeouts++;
      $display("timeout: machine did not halt after %0d status polls", polls);
    end
  endtask

  task automatic finish_run(input int exp_err);
    logic [31:0] status;
    logic [31:0] data;
    logic        err;
    int          r;
    wait_halted(status);
    if (timeouts != 0) return;
    check_eq("status.busy", status[0], 1'b0);
    check_eq("status.halted", status[1], exp_halted);
    check_eq("status.error", status[10:8], 32'(exp_err));
    for (r = 0; r < num_regs; r++) begin
      apb_read(addr_reg_base + 10'(4*r), data, err);
      check_eq($sformatf("r%0d", r), data, {16'h0, exp_regs[r]});
    end
  endtask

  task automatic run_program();
    int   exp_err;
    logic err;
    load_program();
    exp_err = ref_run();
    apb_write(addr_ctrl, 32'h1, err);
    finish_run(exp_err);
  endtask

  initial begin
    logic err;
    int   exp_err;
    int   s;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    rst_n    = 1'b0;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    seed     = 34;
    for (s = 0; s < num_regs; s++) exp_regs[s] = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // all five ops over ranges of one to eight registers with wraparound
    fill_prog();
    put_instr(0, op_num2reg, 0, 7, 16'hfff0);
    put_instr(1, op_reg_plus, 0, 3, 16'h0020);
    put_instr(2, op_reg_minus, 4, 1, 16'hfff5);
    put_instr(3, op_reg_mul, 6, 0, 16'h0100);
    put_instr(4, op_reg_div, 0, 7, 16'h0003);
    put_instr(5, op_num2reg, 24, 5, 16'h8001);
    put_instr(6, op_reg_mul, 24, 5, 16'h0003);
    put_instr(7, op_reg_plus, 31, 0, 16'hbeef);
    put_instr(8, op_exit, 0, 0, 16'h0);
    run_program();

    // status and registers are non-zero now, so aliased decodes would show
    check_read_zero(10'h008);
    check_read_zero(10'h07c);
    check_read_zero(10'h204);
    check_read_zero(10'h280);

    // forward jump over slots 1 and 2, then back to the exit in slot 1
    fill_prog();
    put_instr(0, op_jmp, 0, 0, 16'd6);
    put_instr(1, op_exit, 0, 0, 16'h0);
    put_instr(2, op_num2reg, 0, 3, 16'hdead);
    put_instr(3, op_num2reg, 8, 0, 16'h1234);
    put_instr(4, op_jmp, 0, 0, 16'd2);
    run_program();

    fill_prog();
    put_instr(0, op_reg_plus, 1, 0, 16'h0001);
    put_instr(1, op_reg_div, 1, 0, 16'h0000);  // divide by zero
    put_instr(2, op_num2reg, 1, 0, 16'h0009);
    run_program();

    fill_prog();
    put_instr(0, op_num2reg, 30, 1, 16'h0003);
    put_instr(1, op_reg_plus, 28, 7, 16'h0001);  // 28 + 7 is past r31
    run_program();

    fill_prog();
    put_instr(0, op_reg_mul, 0, 7, 16'h0003);
    put_instr(1, 8'h40, 0, 0, 16'h0001);  // no such opcode
    put_instr(2, op_num2reg, 0, 0, 16'h0000);
    run_program();

    fill_prog();
    put_instr(0, op_num2reg, 10, 0, 16'h0005);
    put_instr(1, op_jmp, 0, 0, 16'd7);  // odd target
    run_program();

    // no exit anywhere so the run halts after word 62
    fill_prog();
    for (s = 0; s < 32; s++) put_instr(s, op_reg_plus, 20, 2, 16'(s + 1));
    run_program();

    // a program write while busy is rejected so the exit in slot 20 never lands
    fill_prog();
    for (s = 0; s < 31; s++) put_instr(s, op_reg_plus, 0, 7, 16'h0101);
    put_instr(31, op_exit, 0, 0, 16'h0);
    load_program();
    exp_err = ref_run();
    apb_write(addr_ctrl, 32'h1, err);
    apb_write(addr_prog_base + 10'(4*40), {16'h0, op_exit, 8'h00}, err);
    if (timeouts == 0) check_eq("pslverr on busy program write", err, 1'b1);
    finish_run(exp_err);

    repeat (20) begin
      random_program();
      run_program();
    end

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
cpu_pkg.sv
core_ifs.sv
prog_mem.sv
apb_host.sv
instr_decode.sv
alu_execute.sv
reg_result.sv
cpu_top.sv
tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
  -f filelist.f -o sim_cpu

output=$(./obj_dir/sim_cpu)
echo "$output"
grep -q "TESTS PASSED" <<< "$output"
